/* Makefile */
# Verilator build and run of the pipelined memory testbench

VERILATOR  ?= verilator
TOP        ?= tb_pipelined_mem
FILE_LIST  ?= tb.f
BUILD_DIR  ?= obj_dir
VFLAGS     ?= --binary --timing --assert
EXTRA_ARGS ?=

SIM := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILE_LIST BUILD_DIR VFLAGS EXTRA_ARGS"

# The run exits nonzero on any failure, so make fails too
test:
	$(VERILATOR) $(VFLAGS) $(EXTRA_ARGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)
	./$(SIM)

clean:
	rm -rf $(BUILD_DIR)

/* mem_golden.txt */
# columns: command address(hex) size data(hex) expect expected_load_data(hex)
# expect is accept, reject or any (retry until accepted); none drains all outstanding work
# fill three lines
store 00000000 double 1122334455667788 any 0
store 00000008 double 0f0e0d0c0b0a0908 any 0
store 00000010 double ffeeddccbbaa9988 any 0
# sized stores, upper data bits must be ignored
store 00000003 byte   ffffffffffffffa5 any 0
store 00000006 half   123456789abcbeef any 0
store 00000014 word   ffffffffcafef00d any 0
store 00000011 byte   deadbeefdeadbe5a any 0
# sized loads, zero-extended, neighbours unchanged
load  00000003 byte   0 any 00000000000000a5
load  00000002 byte   0 any 0000000000000066
load  00000004 byte   0 any 0000000000000044
load  00000006 half   0 any 000000000000beef
load  00000007 half   0 any 000000000000beef
load  00000004 half   0 any 0000000000003344
load  00000000 word   0 any 00000000a5667788
load  00000004 word   0 any 00000000beef3344
load  00000000 double 0 any beef3344a5667788
load  00000010 double 0 any cafef00dbbaa5a88
load  00000011 byte   0 any 000000000000005a
load  00000012 half   0 any 000000000000bbaa
load  00000017 byte   0 any 00000000000000ca
# out-of-range commands are refused and leave the alias untouched
store 00000408 double deaddeaddeaddead reject 0
load  00000400 byte   0 reject 0
store fffffff8 word   0000000012345678 reject 0
load  00000008 double 0 any 0f0e0d0c0b0a0908
# back-to-back burst of NUM_TAGS+1 loads from an idle tracker
none  00000000 double 0 any 0
load  00000000 double 0 accept beef3344a5667788
load  00000008 double 0 accept 0f0e0d0c0b0a0908
load  00000010 double 0 accept cafef00dbbaa5a88
load  00000003 byte   0 accept 00000000000000a5
load  00000014 word   0 reject 0
load  00000014 word   0 any 00000000cafef00d
# mixed traffic under contention
store 00000018 word   0000000012345678 any 0
store 0000001e half   00000000000077aa any 0
load  00000018 word   0 any 0000000012345678
load  0000001e half   0 any 00000000000077aa
store 00000020 double 0123456789abcdef any 0
load  00000024 word   0 any 0000000001234567
load  00000021 byte   0 any 00000000000000cd

/* mem_pkg.sv */
// Memory data formats shared by the request port, the line store and the tag tracker
package mem_pkg;

    //////////////////////////////////////////////////////////////////////
    // Request encodings
    //////////////////////////////////////////////////////////////////////

    typedef enum logic [1:0] {
        MEM_NONE  = 2'h0,
        MEM_LOAD  = 2'h1,
        MEM_STORE = 2'h2
    } mem_cmd_e;

    // Access width inside one line
    typedef enum logic [1:0] {
        BYTE   = 2'h0,
        HALF   = 2'h1,
        WORD   = 2'h2,
        DOUBLE = 2'h3
    } mem_size_e;

    //////////////////////////////////////////////////////////////////////
    // Addresses and lines
    //////////////////////////////////////////////////////////////////////

    typedef logic [31:0] addr_t;  // Byte address

    localparam int LINE_OFFSET_BITS = 3;  // Byte offset within a 64-bit line

    // One line seen at every access width
    typedef union packed {
        logic [7:0][7:0]  bytes;
        logic [3:0][15:0] halves;
        logic [1:0][31:0] words;
        logic [63:0]      dword;
    } mem_line_t;

endpackage

/* mem_store.sv */
// Line storage of the pipelined memory; checks the address, extracts loads, merges stores
`timescale 1ns/1ps

module mem_store import mem_pkg::*; #(
    parameter int MEM_BYTES = 1024
) (
    input  logic      clock,
    input  addr_t     req_addr,
    input  mem_line_t req_data,
    input  mem_size_e req_size,
    input  mem_cmd_e  req_command,
    input  logic      acc_grant,    // Tracker has a free slot this cycle
    output logic      acc_valid,    // Command is a load or store to a legal address
    output logic      acc_load,
    output mem_line_t acc_line      // Zero-extended load result
);

    localparam int LINE_BYTES = 1 << LINE_OFFSET_BITS;
    localparam int LINES      = MEM_BYTES / LINE_BYTES;
    localparam int IDX_W      = (LINES > 1) ? $clog2(LINES) : 1;

    mem_line_t mem_q [LINES];  // Contents unknown until stored

    logic [IDX_W-1:0]            line_idx;
    logic [LINE_OFFSET_BITS-1:0] offset;
    logic                        in_range;
    mem_line_t                   cur_line;
    mem_line_t                   merged;

    //////////////////////////////////////////////////////////////////////
    // Address decode
    //////////////////////////////////////////////////////////////////////

    assign line_idx = req_addr[LINE_OFFSET_BITS +: IDX_W];
    assign offset   = req_addr[LINE_OFFSET_BITS-1:0];
    assign in_range = req_addr < addr_t'(MEM_BYTES);

    assign acc_load  = (req_command == MEM_LOAD);
    assign acc_valid = in_range && (req_command == MEM_LOAD || req_command == MEM_STORE);

    // Out-of-range addresses alias onto some line, but acc_valid stays low
    assign cur_line = mem_q[line_idx];

    //////////////////////////////////////////////////////////////////////
    // Sized load extraction
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        acc_line = '0;  // Upper bytes stay zero
        case (req_size)
            BYTE: begin
                acc_line.bytes[0] = cur_line.bytes[offset];
            end
            HALF: begin
                acc_line.halves[0] = cur_line.halves[offset[LINE_OFFSET_BITS-1:1]];
            end
            WORD: begin
                acc_line.words[0] = cur_line.words[offset[LINE_OFFSET_BITS-1:2]];
            end
            default: begin
                acc_line = cur_line;  // Whole line
            end
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // Sized store merge
    //////////////////////////////////////////////////////////////////////

    // Only the low bits of req_data land in the line; the rest keeps its old value
    always_comb begin
        merged = cur_line;
        case (req_size)
            BYTE: begin
                merged.bytes[offset] = req_data.bytes[0];
            end
            HALF: begin
                merged.halves[offset[LINE_OFFSET_BITS-1:1]] = req_data.halves[0];
            end
            WORD: begin
                merged.words[offset[LINE_OFFSET_BITS-1:2]] = req_data.words[0];
            end
            default: begin
                merged = req_data;
            end
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // Write port
    //////////////////////////////////////////////////////////////////////

    // A refused store leaves memory untouched
    always_ff @(posedge clock) begin
        if (acc_valid && !acc_load && acc_grant) begin
            mem_q[line_idx] <= merged;
        end
    end

endmodule

/* pipelined_mem.sv */
// Top level of the tagged pipelined memory; joins line storage to the tag tracker
`timescale 1ns/1ps

module pipelined_mem import mem_pkg::*, tag_pkg::*; #(
    parameter int NUM_TAGS  = 4,     // 1 to 15 outstanding operations
    parameter int LATENCY   = 6,     // Cycles before a slot may finish
    parameter int MEM_BYTES = 1024
) (
    input  logic      clock,
    input  logic      arst_n,

    // Request, one command per cycle
    input  addr_t     req_addr,
    input  mem_line_t req_data,
    input  mem_size_e req_size,
    input  mem_cmd_e  req_command,

    // Responses
    output tag_t      rsp_tag,   // Zero when refused
    output tag_t      rd_tag,    // Zero when the bus is idle
    output mem_line_t rd_data
);

    //////////////////////////////////////////////////////////////////////
    // Store to tracker handshake
    //////////////////////////////////////////////////////////////////////

    logic      acc_valid;
    logic      acc_load;
    logic      acc_grant;
    mem_line_t acc_line;

    mem_store #(
        .MEM_BYTES (MEM_BYTES)
    ) u_store (
        .clock       (clock),
        .req_addr    (req_addr),
        .req_data    (req_data),
        .req_size    (req_size),
        .req_command (req_command),
        .acc_grant   (acc_grant),
        .acc_valid   (acc_valid),
        .acc_load    (acc_load),
        .acc_line    (acc_line)
    );

    tag_tracker #(
        .NUM_TAGS (NUM_TAGS),
        .LATENCY  (LATENCY)
    ) u_tracker (
        .clock     (clock),
        .arst_n    (arst_n),
        .acc_valid (acc_valid),
        .acc_load  (acc_load),
        .acc_line  (acc_line),
        .acc_grant (acc_grant),
        .rsp_tag   (rsp_tag),
        .rd_tag    (rd_tag),
        .rd_data   (rd_data)
    );

endmodule

/* pipelined_mem_assert.sv */
// Concurrent checks on the tag tracker, attached to every tag_tracker instance by bind
`timescale 1ns/1ps

module pipelined_mem_assert import tag_pkg::*; #(
    parameter int NUM_TAGS = 4
) (
    input logic   clock,
    input logic   arst_n,
    input logic   acc_valid,
    input logic   acc_grant,
    input count_t count_q [1:NUM_TAGS],
    input logic   wait_q  [1:NUM_TAGS],
    input tag_t   rsp_tag,
    input tag_t   rd_tag
);

    logic        all_busy;
    logic [15:0] waiting_prev;  // Waiting flags one edge ago

    // A slot can be reused if it is idle, a store on its last cycle, or a finished load
    always_comb begin
        all_busy = 1'b1;
        for (int i = 1; i <= NUM_TAGS; i++) begin
            if ((!wait_q[i] && count_q[i] <= count_t'(1)) ||
                (wait_q[i] && count_q[i] == '0)) begin
                all_busy = 1'b0;
            end
        end
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            waiting_prev <= '0;
        end else begin
            for (int i = 1; i <= NUM_TAGS; i++) begin
                waiting_prev[i] <= wait_q[i];
            end
        end
    end

    grant_needs_free_slot: assert property (@(posedge clock) disable iff (!arst_n)
        acc_grant |-> !all_busy)
        else $error("acc_grant raised while every slot is busy");

    return_from_waiting_slot: assert property (@(posedge clock) disable iff (!arst_n)
        rd_tag != '0 |-> waiting_prev[rd_tag])
        else $error("rd_tag %0d names a slot that was not waiting", rd_tag);

    tag_only_after_accept: assert property (@(posedge clock) disable iff (!arst_n)
        rsp_tag != '0 |-> $past(acc_valid && acc_grant))
        else $error("rsp_tag %0d without an accepted command", rsp_tag);

endmodule

bind tag_tracker pipelined_mem_assert #(
    .NUM_TAGS (NUM_TAGS)
) u_tracker_assert (
    .clock     (clock),
    .arst_n    (arst_n),
    .acc_valid (acc_valid),
    .acc_grant (acc_grant),
    .count_q   (count_q),
    .wait_q    (wait_q),
    .rsp_tag   (rsp_tag),
    .rd_tag    (rd_tag)
);

/* tag_pkg.sv */
// Transaction bookkeeping types for the tag tracker and its response ports
package tag_pkg;

    //////////////////////////////////////////////////////////////////////
    // Tags
    //////////////////////////////////////////////////////////////////////

    // Zero means no transaction, so a refusal or an idle return bus
    typedef logic [3:0] tag_t;

    //////////////////////////////////////////////////////////////////////
    // Latency countdown
    //////////////////////////////////////////////////////////////////////

    typedef logic [15:0] count_t;  // Cycles left before a slot may finish

endpackage

/* tag_tracker.sv */
// Tag slots for the pipelined memory; allocates tags, counts latency, arbitrates the return bus
`timescale 1ns/1ps

module tag_tracker import mem_pkg::*, tag_pkg::*; #(
    parameter int NUM_TAGS = 4,
    parameter int LATENCY  = 6
) (
    input  logic      clock,
    input  logic      arst_n,
    input  logic      acc_valid,
    input  logic      acc_load,
    input  mem_line_t acc_line,
    output logic      acc_grant,   // Some slot can take a command this cycle
    output tag_t      rsp_tag,
    output tag_t      rd_tag,
    output mem_line_t rd_data
);

    // Slot state, tag i lives in slot i
    count_t    count_q [1:NUM_TAGS];
    logic      wait_q  [1:NUM_TAGS];   // Load finished or pending, needs the bus
    mem_line_t line_q  [1:NUM_TAGS];

    logic [NUM_TAGS:1] slot_free;
    logic              ret_found;
    tag_t              ret_tag;
    tag_t              grant_tag;
    logic              accept;

    //////////////////////////////////////////////////////////////////////
    // Return bus arbitration
    //////////////////////////////////////////////////////////////////////

    // Lowest finished load wins
    always_comb begin
        ret_found = 1'b0;
        ret_tag   = '0;
        for (int i = 1; i <= NUM_TAGS; i++) begin
            if (!ret_found && wait_q[i] && count_q[i] == '0) begin
                ret_found = 1'b1;
                ret_tag   = tag_t'(i);
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Tag allocation
    //////////////////////////////////////////////////////////////////////

    // A store on its last cycle or a load leaving on the bus frees its slot at this edge
    always_comb begin
        for (int i = 1; i <= NUM_TAGS; i++) begin
            slot_free[i] = (!wait_q[i] && count_q[i] <= count_t'(1)) ||
                           (ret_found && ret_tag == tag_t'(i));
        end
    end

    always_comb begin
        grant_tag = '0;
        for (int i = NUM_TAGS; i >= 1; i--) begin
            if (slot_free[i]) begin
                grant_tag = tag_t'(i);  // Last hit is the lowest
            end
        end
    end

    assign acc_grant = |slot_free;
    assign accept    = acc_valid && acc_grant;

    //////////////////////////////////////////////////////////////////////
    // Slot and response registers
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 1; i <= NUM_TAGS; i++) begin
                count_q[i] <= '0;
                wait_q[i]  <= 1'b0;
            end
            rsp_tag <= '0;
            rd_tag  <= '0;
            rd_data <= '0;
        end else begin
            for (int i = 1; i <= NUM_TAGS; i++) begin
                if (ret_found && ret_tag == tag_t'(i)) begin
                    wait_q[i] <= 1'b0;
                end
                if (accept && grant_tag == tag_t'(i)) begin
                    count_q[i] <= count_t'(LATENCY);
                    wait_q[i]  <= acc_load;  // Overrides a same-edge return
                end else if (count_q[i] != '0) begin
                    count_q[i] <= count_q[i] - count_t'(1);
                end
            end
            rsp_tag <= accept ? grant_tag : '0;
            rd_tag  <= ret_tag;
            rd_data <= ret_found ? line_q[ret_tag] : '0;
        end
    end

    // Load data captured at issue
    always_ff @(posedge clock) begin
        for (int i = 1; i <= NUM_TAGS; i++) begin
            if (accept && acc_load && grant_tag == tag_t'(i)) begin
                line_q[i] <= acc_line;
            end
        end
    end

endmodule

/* tb.f */
mem_pkg.sv
tag_pkg.sv
mem_store.sv
tag_tracker.sv
pipelined_mem.sv
pipelined_mem_assert.sv
tb_clock_gen.sv
tb_pipelined_mem.sv

/* tb_clock_gen.sv */
// Testbench clock of 10 ns period with an active-low reset held over the first two rising edges
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int HALF_PERIOD  = 5,
    parameter int RESET_CYCLES = 2
) (
    output logic clock,
    output logic arst_n
);

    initial begin
        clock = 1'b0;
        forever #HALF_PERIOD clock = ~clock;
    end

    initial begin
        arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clock);
        #1 arst_n = 1'b1;  // Release just after an edge
    end

endmodule

/* tb_pipelined_mem.sv */
// Testbench for the pipelined memory; replays the golden operation file and checks tags and data
`timescale 1ns/1ps

module tb_pipelined_mem import mem_pkg::*, tag_pkg::*; #(
    parameter int NUM_TAGS  = 4,
    parameter int LATENCY   = 6,
    parameter int MEM_BYTES = 1024
);

    localparam string GOLDEN_FILE = "mem_golden.txt";
    localparam int    SEED        = 4;
    localparam int    WAIT_LIMIT  = 200;  // Cycles allowed for any single wait
    localparam int    MAX_GAP     = 3;    // Longest random idle gap
    localparam int    EXP_ACCEPT  = 0;
    localparam int    EXP_REJECT  = 1;
    localparam int    EXP_ANY     = 2;

    logic      clock;
    logic      arst_n;
    addr_t     req_addr;
    mem_line_t req_data;
    mem_size_e req_size;
    mem_cmd_e  req_command;
    tag_t      rsp_tag;
    tag_t      rd_tag;
    mem_line_t rd_data;

    // Outstanding loads, indexed by tag
    logic        pending_q   [16];
    logic [63:0] expect_q    [16];
    int          issue_cycle [16];
    string       name_q      [16];
    int          pending_count;
    int          cycle_count;

    tb_clock_gen u_clock_gen (
        .clock  (clock),
        .arst_n (arst_n)
    );

    pipelined_mem #(
        .NUM_TAGS  (NUM_TAGS),
        .LATENCY   (LATENCY),
        .MEM_BYTES (MEM_BYTES)
    ) dut0 (
        .clock       (clock),
        .arst_n      (arst_n),
        .req_addr    (req_addr),
        .req_data    (req_data),
        .req_size    (req_size),
        .req_command (req_command),
        .rsp_tag     (rsp_tag),
        .rd_tag      (rd_tag),
        .rd_data     (rd_data)
    );

    //////////////////////////////////////////////////////////////////////
    // Checking
    //////////////////////////////////////////////////////////////////////

    task automatic stop_failed();
        $display("*** TEST FAILED ***");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (actual !== expected) begin
            $display("MISMATCH %s: expected %h, actual %h", name, expected, actual);
            stop_failed();
        end
    endtask

    // Return bus monitor, called once per cycle
    task automatic collect_return();
        int t;
        if (rd_tag == '0) begin
            check_value("idle return bus", '0, rd_data);
        end else begin
            t = int'(rd_tag);
            if (!pending_q[t]) begin
                $display("Return on tag %0d, which has no load outstanding", t);
                stop_failed();
            end
            if (cycle_count - issue_cycle[t] < LATENCY + 1) begin
                $display("%s: tag %0d returned after %0d cycles, minimum is %0d",
                         name_q[t], t, cycle_count - issue_cycle[t], LATENCY + 1);
                stop_failed();
            end
            check_value({name_q[t], " load data"}, expect_q[t], rd_data);
            pending_q[t] = 1'b0;
            pending_count--;
        end
    endtask

    // Advance to 1 ns after the next rising edge
    task automatic tick();
        @(posedge clock);
        #1;
        cycle_count++;
        collect_return();
        for (int t = 1; t < 16; t++) begin
            if (pending_q[t] && cycle_count - issue_cycle[t] > WAIT_LIMIT) begin
                $display("%s: load on tag %0d never returned", name_q[t], t);
                stop_failed();
            end
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////////////////////////

    task automatic run_op(input string name, input mem_cmd_e cmd, input addr_t addr,
                          input mem_size_e size, input logic [63:0] data,
                          input int exp_code, input logic [63:0] exp_data);
        int   attempts;
        tag_t tag;
        if (exp_code == EXP_ANY) begin
            repeat ($urandom_range(MAX_GAP, 0)) tick();
        end
        attempts = 0;
        do begin
            req_addr    = addr;
            req_data    = data;
            req_size    = size;
            req_command = cmd;
            tick();
            tag = rsp_tag;
            attempts++;
            if (attempts > WAIT_LIMIT) begin
                $display("%s: command refused %0d times in a row", name, attempts);
                stop_failed();
            end
        end while (tag == '0 && exp_code == EXP_ANY);
        req_command = MEM_NONE;
        if (exp_code == EXP_REJECT) begin
            check_value({name, " rsp_tag"}, '0, 64'(tag));
        end else if (tag == '0) begin
            $display("%s: command refused where acceptance was expected", name);
            stop_failed();
        end
        if (tag != '0 && cmd == MEM_LOAD) begin
            if (int'(tag) > NUM_TAGS || pending_q[tag]) begin
                $display("%s: tag %0d is out of range or already outstanding", name, tag);
                stop_failed();
            end
            pending_q[tag]   = 1'b1;
            expect_q[tag]    = exp_data;
            issue_cycle[tag] = cycle_count;
            name_q[tag]      = name;
            pending_count++;
        end
    endtask

    // Wait for every load, then let store slots run out their latency
    task automatic drain();
        int waited;
        waited = 0;
        req_command = MEM_NONE;
        while (pending_count != 0) begin
            tick();
            waited++;
            if (waited > WAIT_LIMIT) begin
                $display("%0d loads still outstanding after %0d cycles", pending_count, waited);
                stop_failed();
            end
        end
        repeat (LATENCY + 1) tick();
    endtask

    task automatic parse_and_run(input string line, input int lineno);
        logic [63:0] cmd_word;
        logic [63:0] size_word;
        logic [63:0] exp_word;
        logic [63:0] data;
        logic [63:0] exp_data;
        addr_t       addr;
        mem_cmd_e    cmd;
        mem_size_e   size;
        int          exp_code;
        if ($sscanf(line, "%s %h %s %h %s %h", cmd_word, addr, size_word, data,
                    exp_word, exp_data) != 6) begin
            $display("Golden line %0d does not have six fields", lineno);
            stop_failed();
        end
        cmd      = (cmd_word == 64'("load"))  ? MEM_LOAD :
                   (cmd_word == 64'("store")) ? MEM_STORE : MEM_NONE;
        size     = (size_word == 64'("byte")) ? BYTE :
                   (size_word == 64'("half")) ? HALF :
                   (size_word == 64'("word")) ? WORD : DOUBLE;
        exp_code = (exp_word == 64'("accept")) ? EXP_ACCEPT :
                   (exp_word == 64'("reject")) ? EXP_REJECT : EXP_ANY;
        if (cmd == MEM_NONE) begin
            drain();
        end else begin
            run_op($sformatf("golden line %0d", lineno), cmd, addr, size, data,
                   exp_code, exp_data);
        end
    endtask

    initial begin
        int    fd;
        int    lineno;
        int    waited;
        string line;
        req_addr      = '0;
        req_data      = '0;
        req_size      = BYTE;
        req_command   = MEM_NONE;
        pending_count = 0;
        cycle_count   = 0;
        for (int t = 0; t < 16; t++) begin
            pending_q[t]   = 1'b0;
            expect_q[t]    = '0;
            issue_cycle[t] = 0;
        end
        void'($urandom(SEED));

        waited = 0;
        while (arst_n !== 1'b1) begin
            @(negedge clock);
            waited++;
            if (waited > WAIT_LIMIT) begin
                $display("Reset never released");
                stop_failed();
            end
        end
        check_value("after reset rsp_tag", '0, 64'(rsp_tag));
        check_value("after reset rd_tag", '0, 64'(rd_tag));
        check_value("after reset rd_data", '0, rd_data);
        tick();

        fd = $fopen(GOLDEN_FILE, "r");
        if (fd == 0) begin
            $display("Cannot open %s", GOLDEN_FILE);
            stop_failed();
        end
        lineno = 0;
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            lineno++;
            if (line.len() == 0 || line[0] == "#" || line[0] == "\n") begin
                continue;  // Comments and blank lines
            end
            parse_and_run(line, lineno);
        end
        $fclose(fd);

        drain();
        if (pending_count == 0) begin
            $display("*** TEST PASSED ***");
            $finish;
        end else begin
            $display("*** TEST FAILED ***");
            $fatal(1, "loads outstanding at the end of the run");
        end
    end

endmodule
